//--- logic/nes_loader_pkg.sv
////////////////////
// Cartridge loader shared definitions
// Widths, states, address map and credit sizes
////////////////////
package nes_loader_pkg;

	////////////////////
	// Data widths
	typedef logic [7:0]   byte_t;          // File or memory byte
	typedef logic [21:0]  mem_addr_t;      // Cartridge memory address
	typedef logic [31:0]  mapper_flags_t;  // Decoded cartridge description
	typedef logic [127:0] cheat_code_t;    // flags, address, compare, replace
	typedef logic [7:0]   page_count_t;    // Header page count
	typedef logic [2:0]   size_code_t;     // log2 size class

	// Loader sequence
	typedef enum logic [2:0] {
		HEADER,
		PRG,
		CHR,
		DISCARD,  // Cheat file, nothing goes to memory
		ERROR,
		DONE
	} load_state_t;

	////////////////////
	// iNES layout
	localparam int HEADER_BYTES   = 16;
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;

	// PRG starts at zero, CHR sits in the upper half
	localparam mem_addr_t CHR_BASE = 22'h200000;

	// Cheat file record size
	localparam int CHEAT_BYTES = 16;

	////////////////////
	// Flow control
	localparam int QUEUE_DEPTH  = 4;  // Also the source credit count
	localparam int MEM_CREDITS  = 2;
	localparam int QUEUE_PTR_W  = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W  = $clog2(QUEUE_DEPTH + 1);
	localparam int MEM_CREDIT_W = $clog2(MEM_CREDITS + 1);

	typedef logic [QUEUE_PTR_W-1:0]  queue_ptr_t;
	typedef logic [QUEUE_CNT_W-1:0]  queue_cnt_t;
	typedef logic [MEM_CREDIT_W-1:0] credit_cnt_t;

endpackage

//--- logic/ines_header_parser.sv
////////////////////
// iNES header parser
// Holds the 16 header bytes, checks them and builds the mapper flags
////////////////////
`timescale 1ns/1ps

module ines_header_parser (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          hdr_valid,
	input  logic [3:0]                    hdr_index,
	input  nes_loader_pkg::byte_t         hdr_byte,
	input  logic                          invert_mirroring,
	output logic                          header_ok,
	output nes_loader_pkg::page_count_t   prg_pages,
	output nes_loader_pkg::page_count_t   chr_pages,
	output nes_loader_pkg::mapper_flags_t flags
);

	nes_loader_pkg::byte_t      ines [nes_loader_pkg::HEADER_BYTES];
	nes_loader_pkg::size_code_t prg_size;
	nes_loader_pkg::size_code_t chr_size;
	logic                       magic_ok;
	logic                       is_nes20;
	logic                       is_dirty;
	logic [7:0]                 mapper;
	logic [7:0]                 ines2_mapper;
	logic [3:0]                 prg_ram;

	// Smallest k with pages <= 2**k, capped at 7
	function automatic nes_loader_pkg::size_code_t size_code(
		input nes_loader_pkg::page_count_t pages
	);
		nes_loader_pkg::size_code_t k;
		k = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (32'(pages) <= (32'd1 << i))
				k = 3'(i);
		end
		return k;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int i = 0; i < nes_loader_pkg::HEADER_BYTES; i++)
				ines[i] <= '0;
		end else if (hdr_valid) begin
			ines[hdr_index] <= hdr_byte;
		end
	end

	////////////////////
	// Header checks

	// "NES" followed by MS-DOS EOF
	assign magic_ok = (ines[0] == 8'h4E) && (ines[1] == 8'h45) &&
	                  (ines[2] == 8'h53) && (ines[3] == 8'h1A);
	assign header_ok = magic_ok && !ines[6][2];  // No trainer support

	assign prg_pages = ines[4];
	assign chr_pages = ines[5];  // Zero means CHR RAM
	assign prg_size  = size_code(prg_pages);
	assign chr_size  = size_code(chr_pages);

	assign is_nes20 = (ines[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 && ((ines[9][7:1] != '0) ||
	                                (ines[10] != '0) || (ines[11] != '0) ||
	                                (ines[12] != '0) || (ines[13] != '0) ||
	                                (ines[14] != '0) || (ines[15] != '0));

	////////////////////
	// Flags word
	assign mapper       = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};
	assign ines2_mapper = is_nes20 ? ines[8] : 8'h00;
	assign prg_ram      = is_nes20 ? ines[10][3:0] : 4'h0;

	assign flags = {
		2'b00,
		prg_ram,                        // 29:26
		ines[6][1],                     // Battery save
		ines2_mapper,                   // 24:17
		ines[6][3],                     // Four screen
		(chr_pages == '0),              // CHR RAM
		ines[6][0] ^ invert_mirroring,  // Mirroring
		chr_size,
		prg_size,
		mapper
	};

endmodule

//--- logic/rom_load_fsm.sv
////////////////////
// ROM load sequencer
// Sorts file bytes into header, PRG, CHR, cheat or discard
// and numbers their memory addresses
////////////////////
`timescale 1ns/1ps

module rom_load_fsm (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        download,
	input  logic                        file_is_cheat,
	input  logic                        file_valid,
	input  nes_loader_pkg::byte_t       file_byte,
	input  logic                        header_ok,
	input  nes_loader_pkg::page_count_t prg_pages,
	input  nes_loader_pkg::page_count_t chr_pages,
	output logic                        hdr_valid,
	output logic [3:0]                  hdr_index,
	output nes_loader_pkg::byte_t       hdr_byte,
	output logic                        enq_valid,
	output nes_loader_pkg::byte_t       enq_byte,
	output nes_loader_pkg::mem_addr_t   enq_addr,
	output logic                        enq_write,
	output logic                        cheat_byte_valid,
	output nes_loader_pkg::byte_t       cheat_byte,
	output logic                        loader_busy,
	output logic                        loader_done,
	output logic                        loader_error
);

	nes_loader_pkg::load_state_t state, cur_state, next_state;
	nes_loader_pkg::mem_addr_t   byte_cnt, cur_cnt, next_cnt;  // Header index, then countdown
	nes_loader_pkg::mem_addr_t   addr_cnt, next_addr;
	logic                        download_q;
	logic                        download_rise;

	assign download_rise = download && !download_q;

	// A new download counts from its very first cycle
	assign cur_state = download_rise ? nes_loader_pkg::HEADER : state;
	assign cur_cnt   = download_rise ? '0 : byte_cnt;

	always_comb begin
		next_state = cur_state;
		next_cnt   = cur_cnt;
		next_addr  = addr_cnt;
		case (cur_state)
			nes_loader_pkg::HEADER: begin
				if (download && file_is_cheat) begin
					next_state = nes_loader_pkg::DISCARD;
				end else if (file_valid) begin
					next_cnt = cur_cnt + 1'b1;
					// Pages and magic are stored by the last header byte
					if (cur_cnt == nes_loader_pkg::mem_addr_t'(nes_loader_pkg::HEADER_BYTES - 1)) begin
						if (!header_ok) begin
							next_state = nes_loader_pkg::ERROR;
						end else if (prg_pages != '0) begin
							next_state = nes_loader_pkg::PRG;
							next_cnt   = nes_loader_pkg::mem_addr_t'(prg_pages * nes_loader_pkg::PRG_PAGE_BYTES);
							next_addr  = '0;
						end else if (chr_pages != '0) begin
							next_state = nes_loader_pkg::CHR;
							next_cnt   = nes_loader_pkg::mem_addr_t'(chr_pages * nes_loader_pkg::CHR_PAGE_BYTES);
							next_addr  = nes_loader_pkg::CHR_BASE;
						end else begin
							next_state = nes_loader_pkg::DONE;
						end
					end
				end
			end
			nes_loader_pkg::PRG: begin
				if (file_valid) begin
					next_cnt  = cur_cnt - 1'b1;
					next_addr = addr_cnt + 1'b1;
					if (cur_cnt == nes_loader_pkg::mem_addr_t'(1)) begin
						if (chr_pages != '0) begin
							next_state = nes_loader_pkg::CHR;
							next_cnt   = nes_loader_pkg::mem_addr_t'(chr_pages * nes_loader_pkg::CHR_PAGE_BYTES);
							next_addr  = nes_loader_pkg::CHR_BASE;
						end else begin
							next_state = nes_loader_pkg::DONE;
						end
					end
				end
			end
			nes_loader_pkg::CHR: begin
				if (file_valid) begin
					next_cnt  = cur_cnt - 1'b1;
					next_addr = addr_cnt + 1'b1;
					if (cur_cnt == nes_loader_pkg::mem_addr_t'(1))
						next_state = nes_loader_pkg::DONE;
				end
			end
			default: ;  // DISCARD, ERROR and DONE swallow the rest
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state            <= nes_loader_pkg::HEADER;
			byte_cnt         <= '0;
			addr_cnt         <= '0;
			download_q       <= 1'b0;
			enq_valid        <= 1'b0;
			enq_write        <= 1'b0;
			cheat_byte_valid <= 1'b0;
		end else begin
			state            <= next_state;
			byte_cnt         <= next_cnt;
			addr_cnt         <= next_addr;
			download_q       <= download;
			enq_valid        <= file_valid;  // Every byte goes through the queue
			enq_write        <= file_valid && ((cur_state == nes_loader_pkg::PRG) ||
			                                   (cur_state == nes_loader_pkg::CHR));
			cheat_byte_valid <= file_valid && file_is_cheat;
		end
	end

	// Payload stage
	always_ff @(posedge clk) begin
		enq_byte <= file_byte;
		enq_addr <= addr_cnt;
	end

	assign hdr_valid  = file_valid && !file_is_cheat && (cur_state == nes_loader_pkg::HEADER);
	assign hdr_index  = cur_cnt[3:0];
	assign hdr_byte   = file_byte;
	assign cheat_byte = enq_byte;

	assign loader_busy  = (state == nes_loader_pkg::PRG) || (state == nes_loader_pkg::CHR);
	assign loader_done  = (state == nes_loader_pkg::DONE) || (state == nes_loader_pkg::ERROR);
	assign loader_error = (state == nes_loader_pkg::ERROR);

	// Queue entries only come from accepted source bytes
	assert property (@(posedge clk) disable iff (reset_nes)
		enq_valid |-> $past(file_valid));

endmodule

//--- logic/mem_write_queue.sv
////////////////////
// Memory write queue
// Issues writes against memory credits, returns source credits
////////////////////
`timescale 1ns/1ps

module mem_write_queue (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      enq_valid,
	input  nes_loader_pkg::byte_t     enq_byte,
	input  nes_loader_pkg::mem_addr_t enq_addr,
	input  logic                      enq_write,
	input  logic                      mem_credit,
	output logic                      mem_write,
	output nes_loader_pkg::mem_addr_t mem_addr,
	output nes_loader_pkg::byte_t     mem_data,
	output logic                      file_credit
);

	nes_loader_pkg::byte_t       data_mem  [nes_loader_pkg::QUEUE_DEPTH];
	nes_loader_pkg::mem_addr_t   addr_mem  [nes_loader_pkg::QUEUE_DEPTH];
	logic                        write_mem [nes_loader_pkg::QUEUE_DEPTH];
	nes_loader_pkg::queue_ptr_t  wr_ptr;
	nes_loader_pkg::queue_ptr_t  rd_ptr;
	nes_loader_pkg::queue_cnt_t  count;
	nes_loader_pkg::credit_cnt_t credits;  // Writes memory can still take
	logic                        pop;

	////////////////////
	// Entry storage
	always_ff @(posedge clk) begin
		if (enq_valid) begin
			data_mem[wr_ptr]  <= enq_byte;
			addr_mem[wr_ptr]  <= enq_addr;
			write_mem[wr_ptr] <= enq_write;
		end
	end

	// Writes wait for a memory credit while other entries retire at once
	assign pop = (count != '0) && (!write_mem[rd_ptr] || (credits != '0));

	assign file_credit = pop;
	assign mem_write   = pop && write_mem[rd_ptr];
	assign mem_addr    = addr_mem[rd_ptr];
	assign mem_data    = data_mem[rd_ptr];

	////////////////////
	// Pointers and counters
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= nes_loader_pkg::credit_cnt_t'(nes_loader_pkg::MEM_CREDITS);
		end else begin
			if (enq_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count   <= count + nes_loader_pkg::queue_cnt_t'(enq_valid)
			                 - nes_loader_pkg::queue_cnt_t'(pop);
			credits <= credits + nes_loader_pkg::credit_cnt_t'(mem_credit)
			                   - nes_loader_pkg::credit_cnt_t'(mem_write);
		end
	end

	// Source credits keep the queue from overfilling
	assert property (@(posedge clk) disable iff (reset_nes)
		enq_valid |-> (count != nes_loader_pkg::queue_cnt_t'(nes_loader_pkg::QUEUE_DEPTH)));

	// Memory never answers more writes than were issued
	assert property (@(posedge clk) disable iff (reset_nes)
		credits <= nes_loader_pkg::credit_cnt_t'(nes_loader_pkg::MEM_CREDITS));

endmodule

//--- logic/cheat_code_assembler.sv
////////////////////
// Cheat code assembler
// Packs 16 file bytes into one 128-bit cheat
////////////////////
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        download,
	input  logic                        cheat_byte_valid,
	input  nes_loader_pkg::byte_t       cheat_byte,
	output nes_loader_pkg::cheat_code_t cheat_code,
	output logic                        cheat_valid
);

	logic [3:0] byte_idx;  // Position within the current record
	logic [6:0] bit_pos;
	logic       download_q;

	// Word 3 - idx/4 holds the byte, little endian inside the word
	assign bit_pos = {~byte_idx[3:2], byte_idx[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			byte_idx    <= '0;
			download_q  <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			download_q  <= download;
			cheat_valid <= cheat_byte_valid &&
			               (byte_idx == 4'(nes_loader_pkg::CHEAT_BYTES - 1));
			if (download && !download_q)
				byte_idx <= '0;  // New file starts a new record
			else if (cheat_byte_valid)
				byte_idx <= byte_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cheat_byte_valid)
			cheat_code[bit_pos +: 8] <= cheat_byte;
	end

endmodule

//--- logic/cart_loader_top.sv
////////////////////
// Cartridge loader top level
// Header parser, sequencer, write queue and cheat assembler
////////////////////
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          invert_mirroring,
	// Byte source
	input  logic                          download,
	input  logic                          file_is_cheat,
	input  logic                          file_valid,
	input  nes_loader_pkg::byte_t         file_byte,
	output logic                          file_credit,
	// Memory
	output logic                          mem_write,
	output nes_loader_pkg::mem_addr_t     mem_addr,
	output nes_loader_pkg::byte_t         mem_data,
	input  logic                          mem_credit,
	// Status
	output logic                          loader_busy,
	output logic                          loader_done,
	output logic                          loader_error,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output nes_loader_pkg::cheat_code_t   cheat_code,
	output logic                          cheat_valid
);

	logic                        hdr_valid;
	logic [3:0]                  hdr_index;
	nes_loader_pkg::byte_t       hdr_byte;
	logic                        header_ok;
	nes_loader_pkg::page_count_t prg_pages;
	nes_loader_pkg::page_count_t chr_pages;
	logic                        enq_valid;
	nes_loader_pkg::byte_t       enq_byte;
	nes_loader_pkg::mem_addr_t   enq_addr;
	logic                        enq_write;
	logic                        cheat_byte_valid;
	nes_loader_pkg::byte_t       cheat_byte;

	ines_header_parser ines_header_parser_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.hdr_valid        (hdr_valid),
		.hdr_index        (hdr_index),
		.hdr_byte         (hdr_byte),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (mapper_flags)
	);

	rom_load_fsm rom_load_fsm_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.file_is_cheat    (file_is_cheat),
		.file_valid       (file_valid),
		.file_byte        (file_byte),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.hdr_valid        (hdr_valid),
		.hdr_index        (hdr_index),
		.hdr_byte         (hdr_byte),
		.enq_valid        (enq_valid),
		.enq_byte         (enq_byte),
		.enq_addr         (enq_addr),
		.enq_write        (enq_write),
		.cheat_byte_valid (cheat_byte_valid),
		.cheat_byte       (cheat_byte),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_error     (loader_error)
	);

	mem_write_queue mem_write_queue_i (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.enq_valid   (enq_valid),
		.enq_byte    (enq_byte),
		.enq_addr    (enq_addr),
		.enq_write   (enq_write),
		.mem_credit  (mem_credit),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.file_credit (file_credit)
	);

	cheat_code_assembler cheat_code_assembler_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.cheat_byte_valid (cheat_byte_valid),
		.cheat_byte       (cheat_byte),
		.cheat_code       (cheat_code),
		.cheat_valid      (cheat_valid)
	);

endmodule

//--- verification/cart_loader_cases.svh
////////////////////
// Loader test cases
// One row per download, plus the expected mapper flags rule
////////////////////
`ifndef CART_LOADER_CASES_SVH
`define CART_LOADER_CASES_SVH

localparam int NUM_ROWS   = 6;
localparam int KIND_ROM   = 0;
localparam int KIND_CHEAT = 1;  // Sends ROW_EXTRA bytes and no header

// PRG only, dirty PRG+CHR, NES 2.0, bad magic, trainer, cheat file
localparam int   ROW_KIND   [NUM_ROWS] = '{0, 0, 0, 0, 0, 1};
localparam logic ROW_INVERT [NUM_ROWS] = '{0, 1, 0, 0, 0, 0};
localparam int   ROW_EXTRA  [NUM_ROWS] = '{0, 5, 3, 10, 7, 32};  // Trailing bytes
localparam logic ROW_ERROR  [NUM_ROWS] = '{0, 0, 0, 1, 1, 0};

localparam logic [7:0] ROW_HEADER [NUM_ROWS][16] = '{
	'{'h4E, 'h45, 'h53, 'h1A, 'h01, 'h00, 'h10, 'h00,
	  'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00},
	'{'h4E, 'h45, 'h53, 'h1A, 'h01, 'h01, 'h43, 'h20,
	  'h00, 'h00, 'h00, 'h00, 'h44, 'h00, 'h00, 'h00},  // Junk in byte 12
	'{'h4E, 'h45, 'h53, 'h1A, 'h02, 'h01, 'h28, 'h18,
	  'h03, 'h02, 'h07, 'h00, 'h00, 'h00, 'h00, 'h00},
	'{'h4E, 'h45, 'h5A, 'h1A, 'h01, 'h00, 'h00, 'h00,
	  'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00},
	'{'h4E, 'h45, 'h53, 'h1A, 'h01, 'h00, 'h04, 'h00,
	  'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00},
	'{'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00,
	  'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00}
};

// Size class of a page count
function automatic logic [2:0] size_class(input logic [7:0] pages);
	for (int k = 0; k < 7; k++) begin
		if (int'(pages) <= (1 << k))
			return 3'(k);
	end
	return 3'd7;
endfunction

function automatic nes_loader_pkg::mapper_flags_t expected_flags(input int r);
	logic [7:0]                    h [16];
	logic                          nes20;
	logic                          dirty;
	nes_loader_pkg::mapper_flags_t f;
	h     = ROW_HEADER[r];
	nes20 = (h[7][3:2] == 2'b10);
	dirty = (h[9][7:1] != 7'd0);
	for (int i = 10; i < 16; i++)
		dirty = dirty || (h[i] != 8'd0);
	dirty    = dirty && !nes20;
	f        = '0;
	f[3:0]   = h[6][7:4];
	f[7:4]   = dirty ? 4'h0 : h[7][7:4];
	f[10:8]  = size_class(h[4]);
	f[13:11] = size_class(h[5]);
	f[14]    = h[6][0] ^ ROW_INVERT[r];
	f[15]    = (h[5] == 8'd0);  // CHR RAM
	f[16]    = h[6][3];
	f[24:17] = nes20 ? h[8] : 8'h00;
	f[25]    = h[6][1];
	f[29:26] = nes20 ? h[10][3:0] : 4'h0;
	return f;
endfunction

`endif

//--- verification/cart_loader_tb.sv
////////////////////
// Cartridge loader testbench
// Credit-respecting byte source and memory model around the loader
////////////////////
`timescale 1ns/1ps

module cart_loader_tb;

	logic                          clk;
	logic                          reset_nes;
	logic                          invert_mirroring;
	logic                          download;
	logic                          file_is_cheat;
	logic                          file_valid;
	nes_loader_pkg::byte_t         file_byte;
	logic                          file_credit;
	logic                          mem_write;
	nes_loader_pkg::mem_addr_t     mem_addr;
	nes_loader_pkg::byte_t         mem_data;
	logic                          mem_credit;
	logic                          loader_busy;
	logic                          loader_done;
	logic                          loader_error;
	nes_loader_pkg::mapper_flags_t mapper_flags;
	nes_loader_pkg::cheat_code_t   cheat_code;
	logic                          cheat_valid;

	////////////////////
	// Models and counters
	nes_loader_pkg::byte_t model        [nes_loader_pkg::mem_addr_t];  // Memory contents
	nes_loader_pkg::byte_t expected_mem [nes_loader_pkg::mem_addr_t];
	nes_loader_pkg::byte_t cheat_bytes  [$];
	int unsigned           response_due [$];  // Cycle of each mem_credit
	int unsigned           cycle;
	int                    outstanding;  // Bytes without credit back
	int                    unanswered;   // Writes without mem_credit
	int                    credits_back;
	int                    cheat_seen;
	int unsigned           prg_bytes;
	int unsigned           chr_bytes;
	logic                  writes_allowed;

	`include "cart_loader_cases.svh"

	cart_loader_top cart_loader_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic show_mismatch(input string name, input logic [127:0] got,
	                             input logic [127:0] exp);
		$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		$display("ERRORS FOUND");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("%s at %0t ns", what, $time);
		$display("ERRORS FOUND");
		$fatal(1, "check failed");
	endtask

	// Byte i lands little endian in word 3 - i/4
	function automatic nes_loader_pkg::cheat_code_t expected_cheat(input int group);
		nes_loader_pkg::cheat_code_t code;
		for (int i = 0; i < 16; i++)
			code[(3 - i / 4) * 32 + (i % 4) * 8 +: 8] = cheat_bytes[group * 16 + i];
		return code;
	endfunction

	function automatic logic write_in_range(input nes_loader_pkg::mem_addr_t addr);
		int unsigned a;
		a = 32'(addr);
		return writes_allowed && ((a < prg_bytes) || ((a >= nes_loader_pkg::CHR_BASE) &&
		       (a < nes_loader_pkg::CHR_BASE + chr_bytes)));
	endfunction

	////////////////////
	// Sample outputs once per cycle and then answer memory
	task automatic tick();
		@(negedge clk);
		cycle++;
		file_valid = 1'b0;
		mem_credit = 1'b0;
		if (file_credit) begin
			assert (outstanding > 0)
			else report_failure("file_credit came with no byte outstanding");
			outstanding--;
			credits_back++;
		end
		if (mem_write) begin
			assert (write_in_range(mem_addr))
			else report_failure("memory write outside allowed ranges");
			model[mem_addr] = mem_data;
			unanswered++;
			assert (unanswered <= nes_loader_pkg::MEM_CREDITS)
			else report_failure("more writes in flight than memory credits");
			response_due.push_back(cycle + $urandom_range(5));  // 0 to 5 cycles late
		end
		if (response_due.size() > 0 && response_due[0] <= cycle) begin
			void'(response_due.pop_front());
			mem_credit = 1'b1;
			unanswered--;
		end
		if (cheat_valid) begin
			assert ((cheat_seen + 1) * 16 <= cheat_bytes.size())
			else report_failure("cheat_valid before 16 new cheat bytes");
			assert (cheat_code == expected_cheat(cheat_seen))
			else show_mismatch("cheat_code", cheat_code, expected_cheat(cheat_seen));
			cheat_seen++;
		end
	endtask

	task automatic send_byte(input int r, input int k);
		nes_loader_pkg::byte_t b;
		int unsigned           pay;
		b   = 8'($urandom);
		pay = k - nes_loader_pkg::HEADER_BYTES;
		if (ROW_KIND[r] == KIND_CHEAT)
			cheat_bytes.push_back(b);
		else if (k < nes_loader_pkg::HEADER_BYTES)
			b = ROW_HEADER[r][k];
		else if (writes_allowed && pay < prg_bytes)
			expected_mem[nes_loader_pkg::mem_addr_t'(pay)] = b;
		else if (writes_allowed && pay < prg_bytes + chr_bytes)
			expected_mem[nes_loader_pkg::CHR_BASE + nes_loader_pkg::mem_addr_t'(pay - prg_bytes)] = b;
		// Payload follows a good header, so the loader is busy
		if (writes_allowed && k >= nes_loader_pkg::HEADER_BYTES && pay < prg_bytes + chr_bytes) begin
			assert (loader_busy) else show_mismatch("loader_busy", loader_busy, 1'b1);
		end
		file_byte  = b;
		file_valid = 1'b1;
		outstanding++;
	endtask

	task automatic run_row(input int r);
		int total;
		int k;
		int idle;
		model.delete();
		expected_mem.delete();
		cheat_bytes.delete();
		credits_back = 0;
		cheat_seen   = 0;
		prg_bytes    = (ROW_KIND[r] == KIND_ROM) ? ROW_HEADER[r][4] * nes_loader_pkg::PRG_PAGE_BYTES : 0;
		chr_bytes    = (ROW_KIND[r] == KIND_ROM) ? ROW_HEADER[r][5] * nes_loader_pkg::CHR_PAGE_BYTES : 0;
		total        = ROW_EXTRA[r];
		if (ROW_KIND[r] == KIND_ROM)
			total += nes_loader_pkg::HEADER_BYTES + prg_bytes + chr_bytes;
		writes_allowed = (ROW_KIND[r] == KIND_ROM) && !ROW_ERROR[r];
		tick();
		download         = 1'b1;
		file_is_cheat    = (ROW_KIND[r] == KIND_CHEAT);
		invert_mirroring = ROW_INVERT[r];
		k    = 0;
		idle = 0;
		while (k < total) begin
			tick();
			idle++;
			assert (idle < 200) else report_failure("byte source got no credit back in time");
			if (outstanding < nes_loader_pkg::QUEUE_DEPTH && $urandom_range(3) != 0) begin
				send_byte(r, k);
				k++;
				idle = 0;
			end
		end
		idle = 0;
		while (outstanding > 0 || response_due.size() > 0) begin  // Drain queue and memory
			tick();
			idle++;
			assert (idle < 200) else report_failure("write queue did not drain in time");
		end
		assert (credits_back == total) else show_mismatch("file_credit count", credits_back, total);
		assert (loader_error == ROW_ERROR[r]) else show_mismatch("loader_error", loader_error, ROW_ERROR[r]);
		if (ROW_KIND[r] == KIND_CHEAT) begin
			assert (cheat_seen == total / 16) else show_mismatch("cheat_valid count", cheat_seen, total / 16);
		end else begin
			assert (loader_done) else show_mismatch("loader_done", loader_done, 1'b1);
			assert (!loader_busy) else show_mismatch("loader_busy", loader_busy, 1'b0);
			if (!ROW_ERROR[r]) begin
				assert (mapper_flags == expected_flags(r))
				else show_mismatch("mapper_flags", mapper_flags, expected_flags(r));
				foreach (expected_mem[a]) begin
					assert (model.exists(a)) else report_failure("payload byte never written to memory");
					assert (model[a] == expected_mem[a])
					else show_mismatch($sformatf("mem_data at %h", a), model[a], expected_mem[a]);
				end
			end
		end
		tick();
		download = 1'b0;
		tick();
	endtask

	initial begin
		void'($urandom(32'hcdc6bb81));
		reset_nes        = 1'b1;
		invert_mirroring = 1'b0;
		download         = 1'b0;
		file_is_cheat    = 1'b0;
		file_valid       = 1'b0;
		file_byte        = '0;
		mem_credit       = 1'b0;
		cycle            = 0;
		outstanding      = 0;
		unanswered       = 0;
		repeat (4) @(negedge clk);
		reset_nes = 1'b0;
		assert (!file_credit && !mem_write && !cheat_valid && !loader_busy &&
		        !loader_done && !loader_error) else report_failure("outputs not low after reset");
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- list.f
+incdir+verification
logic/nes_loader_pkg.sv
logic/ines_header_parser.sv
logic/rom_load_fsm.sv
logic/mem_write_queue.sv
logic/cheat_code_assembler.sv
logic/cart_loader_top.sv
verification/cart_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module cart_loader_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vcart_loader_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
